// File: bench/tb_clock_gen.sv
`timescale 1ns/10ps

// free running write clock and power-on reset for the bench
module tb_clock_gen #(
	parameter int period       = 4, // ns
	parameter int reset_cycles = 5
) (
	output logic write_clk,
	output logic rstn
);

	initial begin
		write_clk = 1'b0;
		forever #(period / 2) write_clk = ~write_clk;
	end

	// release away from the rising edge
	initial begin
		rstn = 1'b0;
		repeat (reset_cycles) @(posedge write_clk);
		@(negedge write_clk);
		rstn = 1'b1;
	end

endmodule

// File: bench/vn_refresh_tb.sv
`timescale 1ns/10ps
`include "vn_refresh_defs.svh"

module vn_refresh_tb import vn_refresh_pkg::*; ();

	localparam int         clk_period = 4;
	localparam int         num_runs   = 4; // one full run then three random ones
	localparam page_addr_t last_page  = page_addr_t'(`VN_PAGES_PER_ITER - 1);

	logic       write_clk;
	logic       rstn;
	logic       start;
	iter_cnt_t  max_iter;
	ram_wr_t    ram_wr;
	iter_cnt_t  iter_cnt;
	logic       busy;
	logic       done;

	int         seed = 7181;
	int         run_len [num_runs]; // max_iter per run
	int         watchdog_cycles;
	bit         plan_ready;

	iter_cnt_t  exp_iter;  // iteration of the next expected write
	page_addr_t exp_page;  // page of the next expected write
	iter_cnt_t  run_max;   // max_iter of the accepted start
	int         wr_count;  // writes seen in this run
	logic       run_seen;  // first start accepted
	logic       in_run;    // accepted start seen, done not yet
	page_data_t exp_a;
	page_data_t exp_b;

	tb_clock_gen #(.period(clk_period), .reset_cycles(5)) tb_clock_gen_inst (
		.write_clk(write_clk),
		.rstn     (rstn)
	);

	vn_refresh_top vn_refresh_top_inst (
		.write_clk(write_clk),
		.rstn     (rstn),
		.start    (start),
		.max_iter (max_iter),
		.ram_wr   (ram_wr),
		.iter_cnt (iter_cnt),
		.busy     (busy),
		.done     (done)
	);

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic report_mismatch(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		stop_on_failure($sformatf("ERROR %s expected %0h actual %0h", test, expected, actual));
	endtask

	//////////////////////
	// reference model

	// table word: low byte of 3x plus the group seed
	function automatic page_data_t rule_word(input iter_cnt_t iter, input page_addr_t page,
		input bit region_b);
		int x;
		int s;
		x = (iter % `VN_ITERS_PER_GROUP) * `VN_PAGES_PER_ITER + page;
		if (region_b)
			x = x + `VN_ROM_B_OFFSET; // type-B words sit above the A region
		s = (iter < `VN_ITERS_PER_GROUP) ? `VN_ROM_SEED_G0 : `VN_ROM_SEED_G1;
		return page_data_t'((3 * x + s) % 256);
	endfunction

	assign exp_a = rule_word(exp_iter, exp_page, 1'b0);
	assign exp_b = rule_word(exp_iter, exp_page, 1'b1);

	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			exp_iter <= '0;
			exp_page <= '0;
			run_max  <= '0;
			wr_count <= 0;
			run_seen <= 1'b0;
			in_run   <= 1'b0;
		end else if (start && !in_run) begin // accepted start, back to iteration 0
			exp_iter <= '0;
			exp_page <= '0;
			run_max  <= max_iter;
			wr_count <= 0;
			run_seen <= 1'b1;
			in_run   <= 1'b1;
		end else begin
			if (done)
				in_run <= 1'b0; // run over
			if (ram_wr.we) begin
				wr_count <= wr_count + 1;
				if (exp_page == last_page) begin
					exp_page <= '0;
					exp_iter <= exp_iter + 1'b1;
				end else
					exp_page <= exp_page + 1'b1;
			end
		end
	end

	//////////////////////
	// checks
	a_reset_idle: assert property (@(posedge write_clk) disable iff (!rstn)
		!run_seen |-> (!busy && !done && !ram_wr.we && iter_cnt == '0))
		else report_mismatch("reset_idle", 32'h0,
			{$sampled(busy), $sampled(done), $sampled(ram_wr.we), $sampled(iter_cnt)});
	a_busy_level: assert property (@(posedge write_clk) disable iff (!rstn)
		busy == in_run) // high from the accepted start through done
		else report_mismatch("busy_level", $sampled(in_run), $sampled(busy));
	a_page_order: assert property (@(posedge write_clk) disable iff (!rstn)
		ram_wr.we |-> (ram_wr.page_addr == exp_page))
		else report_mismatch("page_order", $sampled(exp_page), $sampled(ram_wr.page_addr));
	a_page_gap: assert property (@(posedge write_clk) disable iff (!rstn)
		(ram_wr.we && ram_wr.page_addr != last_page) |=> ram_wr.we)
		else report_mismatch("page_gap", 32'h1, $sampled(ram_wr.we));
	a_data_a: assert property (@(posedge write_clk) disable iff (!rstn)
		ram_wr.we |-> (ram_wr.data.data_a == exp_a))
		else report_mismatch("data_a", $sampled(exp_a), $sampled(ram_wr.data.data_a));
	a_data_b: assert property (@(posedge write_clk) disable iff (!rstn)
		ram_wr.we |-> (ram_wr.data.data_b == exp_b))
		else report_mismatch("data_b", $sampled(exp_b), $sampled(ram_wr.data.data_b));
	a_iter_cnt: assert property (@(posedge write_clk) disable iff (!rstn)
		ram_wr.we |-> (iter_cnt == exp_iter))
		else report_mismatch("iter_cnt", $sampled(exp_iter), $sampled(iter_cnt));
	a_write_in_run: assert property (@(posedge write_clk) disable iff (!rstn)
		ram_wr.we |-> (exp_iter < run_max)) // no page beyond the last iteration
		else report_mismatch("write_in_run", $sampled(run_max), $sampled(exp_iter));
	a_run_length: assert property (@(posedge write_clk) disable iff (!rstn)
		done |-> (wr_count == run_max * `VN_PAGES_PER_ITER))
		else report_mismatch("run_length", $sampled(run_max) * `VN_PAGES_PER_ITER,
			$sampled(wr_count));
	a_final_iter: assert property (@(posedge write_clk) disable iff (!rstn)
		done |-> (iter_cnt == run_max))
		else report_mismatch("final_iter", $sampled(run_max), $sampled(iter_cnt));
	a_done_then_idle: assert property (@(posedge write_clk) disable iff (!rstn)
		done |=> (!done && !busy)) // single pulse, busy drops right after
		else report_mismatch("done_then_idle", 32'h0, {$sampled(done), $sampled(busy)});

	//////////////////////
	// stimulus

	// one accepted start, stray starts while busy, junk on max_iter after sampling
	task automatic run_once(input iter_cnt_t n);
		bit seen_done;
		seen_done = 1'b0;
		@(negedge write_clk);
		start    = 1'b1;
		max_iter = n;
		while (!seen_done) begin
			@(negedge write_clk);
			seen_done = done;
			start     = !seen_done && (($random(seed) & 7) == 0);
			max_iter  = iter_cnt_t'($random(seed));
		end
		repeat (3) @(negedge write_clk); // back in idle
	endtask

	initial begin
		start           = 1'b0;
		max_iter        = '0;
		run_len[0]      = `VN_MAX_ITER;
		watchdog_cycles = 200;
		for (int r = 1; r < num_runs; r++)
			run_len[r] = 1 + ($unsigned($random(seed)) % `VN_MAX_ITER);
		foreach (run_len[r])
			watchdog_cycles += run_len[r] * (`VN_PAGES_PER_ITER + 10);
		plan_ready = 1'b1;
		wait (rstn === 1'b1);
		repeat (4) @(negedge write_clk); // quiet window after reset
		foreach (run_len[r])
			run_once(iter_cnt_t'(run_len[r]));
		$display("SIMULATION PASSED");
		$finish;
	end

	// hang guard sized from the chosen run lengths
	initial begin
		wait (plan_ready);
		#(watchdog_cycles * clk_period);
		stop_on_failure("the DUT hung and did not finish all runs in time");
	end

endmodule

// File: filelist.f
+incdir+source
source/vn_refresh_pkg.sv
source/ib_rom_bank.sv
source/vn_rom_fetch.sv
source/vn_page_writer.sv
source/vn_refresh_ctrl.sv
source/vn_refresh_top.sv
bench/tb_clock_gen.sv
bench/vn_refresh_tb.sv

// File: source/ib_rom_bank.sv
`timescale 1ns/10ps
`include "vn_refresh_defs.svh"

// one group of iteration rom
// both read ports share the same word array like a true dual port bram
// the lower half is the type-A region, the upper half the type-B region
module ib_rom_bank import vn_refresh_pkg::*; #(
	parameter page_data_t seed = `VN_ROM_SEED_G0 // group content seed
) (
	input  logic      write_clk,
	input  rom_rd_t   rom_rd,   // A and B read addresses
	output rom_data_t rom_dout  // registered, one cycle after rom_rd
);

	localparam int rom_depth = 2 ** `VN_ROM_ADDR_BW; // 128 words

	page_data_t mem [0:rom_depth-1];

	//////////////////////
	// content

	// table word at address x
	function automatic page_data_t rom_word(input int x);
		return page_data_t'(`VN_ROM_WORD(x, seed));
	endfunction

	// fixed content rule, stands in for a memory init file
	// A words of iteration i sit at i*16 .. i*16+15
	// B words of the same iteration at 64 + i*16 ..
	initial begin
		for (int i = 0; i < rom_depth; i++) begin
			mem[i] = rom_word(i);
		end
	end

	//////////////////////
	// read ports

	// port A reads the type-A region
	always_ff @(posedge write_clk) begin
		rom_dout.data_a <= mem[rom_rd.addr_a]; // sync read
	end

	// port B reads the type-B region
	always_ff @(posedge write_clk) begin
		rom_dout.data_b <= mem[rom_rd.addr_b]; // sync read
	end

	// no output register beyond the read latch
	// the fetch block adds its own latch after the group mux

endmodule

// File: source/vn_page_writer.sv
`timescale 1ns/10ps
`include "vn_refresh_defs.svh"

// turns the latched page stream into table ram writes
// one page per latch_valid, pages 0 .. 15 per iteration
module vn_page_writer import vn_refresh_pkg::*; (
	input  logic      write_clk,
	input  logic      rstn,
	input  logic      run_clear,   // start of a run
	input  logic      latch_valid,
	input  rom_data_t latch_data,
	output ram_wr_t   ram_wr,
	output logic      iter_finish, // last page written this cycle
	output iter_cnt_t iter_cnt     // finished iterations
);

	localparam page_addr_t last_page = page_addr_t'(`VN_PAGES_PER_ITER - 1);

	page_addr_t page_cnt; // page address of the current write

	//////////////////////
	// page address counter

	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn)
			page_cnt <= '0;
		else if (run_clear)
			page_cnt <= '0; // new run starts on page 0
		else if (latch_valid) begin
			if (page_cnt == last_page)
				page_cnt <= '0; // wrap for the next iteration
			else
				page_cnt <= page_cnt + 1'b1;
		end
	end

	assign iter_finish = latch_valid && (page_cnt == last_page);

	//////////////////////
	// iteration counter

	// visible one cycle after iter_finish
	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn)
			iter_cnt <= '0;
		else if (run_clear)
			iter_cnt <= '0;
		else if (iter_finish)
			iter_cnt <= iter_cnt + 1'b1;
	end

	//////////////////////
	// write command

	assign ram_wr.we        = latch_valid;
	assign ram_wr.page_addr = page_cnt;
	assign ram_wr.data      = latch_data; // A and B words together

	// control must stop fetching once the last iteration is counted
	a_no_write_past_max: assert property (@(posedge write_clk) disable iff (!rstn)
		ram_wr.we |-> (iter_cnt != iter_cnt_t'(`VN_MAX_ITER)));

endmodule

// File: source/vn_refresh_ctrl.sv
`timescale 1ns/10ps
`include "vn_refresh_defs.svh"

// run configuration and iteration sequencing
// IDLE -> LOAD (16 fetch cycles) -> DRAIN (wait last write) -> LOAD or DONE
module vn_refresh_ctrl import vn_refresh_pkg::*; (
	input  logic      write_clk,
	input  logic      rstn,
	input  logic      start,       // pulse, ignored while busy
	input  iter_cnt_t max_iter,    // sampled on an accepted start
	input  logic      iter_finish, // last page of an iteration written
	input  iter_cnt_t cur_iter,    // finished iterations so far
	output logic      fetch_run,
	output logic      iter_start,
	output logic      busy,
	output logic      done,
	output logic      run_clear    // zeroes the writer counters
);

	localparam page_addr_t last_fetch = page_addr_t'(`VN_PAGES_PER_ITER - 1);

	refresh_state_t state;
	iter_cnt_t      max_q;     // configuration register
	page_addr_t     fetch_cnt; // fetch cycles done in this iteration
	logic           start_ok;  // start seen in IDLE
	iter_cnt_t      next_iter; // count once the pending iteration is in

	assign start_ok  = (state == IDLE) && start;
	assign run_clear = start_ok; // counters are zero before iter_start
	assign next_iter = cur_iter + 1'b1;

	//////////////////////
	// sequencing FSM

	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			state      <= IDLE;
			max_q      <= '0;
			fetch_run  <= 1'b0;
			iter_start <= 1'b0;
			fetch_cnt  <= '0;
		end else begin
			iter_start <= 1'b0; // pulse by default
			case (state)
				IDLE: begin
					if (start_ok) begin
						max_q <= max_iter;
						if (max_iter == '0)
							state <= DONE; // empty run
						else begin
							state      <= LOAD;
							iter_start <= 1'b1;
						end
					end
				end
				LOAD: begin
					if (iter_start) begin // base address loads now
						fetch_run <= 1'b1;
						fetch_cnt <= '0;
					end else if (fetch_run) begin
						fetch_cnt <= fetch_cnt + 1'b1;
						if (fetch_cnt == last_fetch) begin
							fetch_run <= 1'b0; // 16 pages issued
							state     <= DRAIN;
						end
					end
				end
				DRAIN: begin
					if (iter_finish) begin
						if (next_iter >= max_q)
							state <= DONE;
						else begin
							state      <= LOAD; // cur_iter has moved on by then
							iter_start <= 1'b1;
						end
					end
				end
				default: state <= IDLE; // DONE lasts one cycle
			endcase
		end
	end

	assign busy = (state != IDLE);
	assign done = (state == DONE);

	//////////////////////
	// checks

	a_done_not_fetching: assert property (@(posedge write_clk) disable iff (!rstn)
		!(done && fetch_run));

	// the writer only finishes an iteration after all its fetches are out
	a_finish_in_drain: assert property (@(posedge write_clk) disable iff (!rstn)
		iter_finish |-> (state == DRAIN));

endmodule

// File: source/vn_refresh_defs.svh
`ifndef VN_REFRESH_DEFS_SVH
`define VN_REFRESH_DEFS_SVH

//////////////////////
// sizes
`define VN_ROM_RD_BW        8   // one rom read port
`define VN_PAGES_PER_ITER   16  // pages refreshed per iteration
`define VN_PAGE_ADDR_BW     4   // clog2 of pages per iteration
`define VN_ITERS_PER_GROUP  4   // iterations held by one rom group
`define VN_MAX_ITER         8   // two groups worth of iterations
`define VN_ITER_BW          4   // has to hold VN_MAX_ITER itself

//////////////////////
// rom layout
// type-A region first, type-B region right after it
`define VN_ROM_ADDR_BW      7
`define VN_ROM_B_OFFSET     64  // ITERS_PER_GROUP * PAGES_PER_ITER

// rom content seeds, one per group
`define VN_ROM_SEED_G0      8'h1d
`define VN_ROM_SEED_G1      8'h5a
// word at address x of a group with seed s
`define VN_ROM_WORD(x, s)   ((((x) * 3) + (s)) & 8'hff)

`endif

// File: source/vn_refresh_pkg.sv
`include "vn_refresh_defs.svh"

package vn_refresh_pkg;

	//////////////////////
	// plain vectors
	typedef logic [`VN_ROM_RD_BW-1:0]    page_data_t; // one table word
	typedef logic [`VN_ROM_ADDR_BW-1:0]  rom_addr_t;
	typedef logic [`VN_PAGE_ADDR_BW-1:0] page_addr_t;
	typedef logic [`VN_ITER_BW-1:0]      iter_cnt_t;  // 0 .. VN_MAX_ITER

	//////////////////////
	// bundles
	typedef struct packed {
		rom_addr_t addr_a; // type-A region
		rom_addr_t addr_b; // type-B region
	} rom_rd_t;

	typedef struct packed {
		page_data_t data_a;
		page_data_t data_b;
	} rom_data_t;

	typedef struct packed {
		logic       we;
		page_addr_t page_addr;
		rom_data_t  data;
	} ram_wr_t; // table ram write port

	typedef enum logic [1:0] {IDLE, LOAD, DRAIN, DONE} refresh_state_t;

endpackage

// File: source/vn_refresh_top.sv
`timescale 1ns/10ps
`include "vn_refresh_defs.svh"

// refresh path top
// ctrl -> fetch -> two rom groups -> fetch latch -> page writer -> table ram
module vn_refresh_top import vn_refresh_pkg::*; (
	input  logic      write_clk,
	input  logic      rstn,
	input  logic      start,
	input  iter_cnt_t max_iter,
	output ram_wr_t   ram_wr,
	output iter_cnt_t iter_cnt, // also fed back as cur_iter
	output logic      busy,
	output logic      done
);

	logic      fetch_run;
	logic      iter_start;
	logic      run_clear;
	logic      iter_finish;
	rom_rd_t   rom_rd;       // shared by both groups
	rom_data_t rom_dout_g0;
	rom_data_t rom_dout_g1;
	rom_data_t latch_data;
	logic      latch_valid;

	//////////////////////
	// control

	vn_refresh_ctrl vn_refresh_ctrl_inst (
		.write_clk  (write_clk),
		.rstn       (rstn),
		.start      (start),
		.max_iter   (max_iter),
		.iter_finish(iter_finish),
		.cur_iter   (iter_cnt),
		.fetch_run  (fetch_run),
		.iter_start (iter_start),
		.busy       (busy),
		.done       (done),
		.run_clear  (run_clear)
	);

	//////////////////////
	// rom read path

	vn_rom_fetch vn_rom_fetch_inst (
		.write_clk  (write_clk),
		.rstn       (rstn),
		.fetch_run  (fetch_run),
		.iter_start (iter_start),
		.cur_iter   (iter_cnt),
		.rom_dout_g0(rom_dout_g0),
		.rom_dout_g1(rom_dout_g1),
		.rom_rd     (rom_rd),
		.latch_data (latch_data),
		.latch_valid(latch_valid)
	);

	// both groups are read every cycle, the fetch mux picks one
	ib_rom_bank #(.seed(`VN_ROM_SEED_G0)) ib_rom_g0_inst ( // iterations 0 .. 3
		.write_clk(write_clk),
		.rom_rd   (rom_rd),
		.rom_dout (rom_dout_g0)
	);

	ib_rom_bank #(.seed(`VN_ROM_SEED_G1)) ib_rom_g1_inst ( // iterations 4 .. 7
		.write_clk(write_clk),
		.rom_rd   (rom_rd),
		.rom_dout (rom_dout_g1)
	);

	//////////////////////
	// write path

	vn_page_writer vn_page_writer_inst (
		.write_clk  (write_clk),
		.rstn       (rstn),
		.run_clear  (run_clear),
		.latch_valid(latch_valid),
		.latch_data (latch_data),
		.ram_wr     (ram_wr),
		.iter_finish(iter_finish),
		.iter_cnt   (iter_cnt)
	);

endmodule

// File: source/vn_rom_fetch.sv
`timescale 1ns/10ps
`include "vn_refresh_defs.svh"

// A/B read address counters, group select and output latch
// addresses go out in the cycle after iter_start and step while fetch_run
// is high, the latched word comes out two cycles after its address
module vn_rom_fetch import vn_refresh_pkg::*; (
	input  logic      write_clk,
	input  logic      rstn,
	input  logic      fetch_run,    // one cycle per page
	input  logic      iter_start,   // loads base address and group
	input  iter_cnt_t cur_iter,     // iteration about to be fetched
	input  rom_data_t rom_dout_g0,  // iterations 0 .. 3
	input  rom_data_t rom_dout_g1,  // iterations 4 .. 7
	output rom_rd_t   rom_rd,
	output rom_data_t latch_data,
	output logic      latch_valid
);

	rom_addr_t addr_a;       // type-A read address
	rom_addr_t addr_b;       // type-B read address
	iter_cnt_t iter_in_grp;  // iteration index inside its group
	rom_addr_t iter_base;    // first A word of that iteration
	logic      grp_sel;      // iteration switch, 1 = group 1
	logic      rd_valid;     // rom data valid this cycle
	rom_data_t grp_data;     // word of the selected group

	//////////////////////
	// base address

	assign iter_in_grp = iter_cnt_t'(cur_iter % `VN_ITERS_PER_GROUP);
	assign iter_base   = rom_addr_t'(iter_in_grp * `VN_PAGES_PER_ITER);

	//////////////////////
	// read address counters

	// both counters restart at every iteration so no wrap is needed
	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			addr_a <= '0;
			addr_b <= '0;
		end else if (iter_start) begin
			addr_a <= iter_base;
			addr_b <= iter_base + rom_addr_t'(`VN_ROM_B_OFFSET); // B region
		end else if (fetch_run) begin
			addr_a <= addr_a + 1'b1; // next page
			addr_b <= addr_b + 1'b1;
		end
	end

	assign rom_rd.addr_a = addr_a;
	assign rom_rd.addr_b = addr_b;

	// group switch only moves between iterations
	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn)
			grp_sel <= 1'b0;
		else if (iter_start)
			grp_sel <= (cur_iter >= iter_cnt_t'(`VN_ITERS_PER_GROUP));
	end

	//////////////////////
	// valid pipe and latch

	// rom latency then latch latency
	always_ff @(posedge write_clk or negedge rstn) begin
		if (!rstn) begin
			rd_valid    <= 1'b0;
			latch_valid <= 1'b0;
		end else begin
			rd_valid    <= fetch_run;
			latch_valid <= rd_valid;
		end
	end

	assign grp_data = grp_sel ? rom_dout_g1 : rom_dout_g0; // group mux

	always_ff @(posedge write_clk) begin
		latch_data <= grp_data; // payload only
	end

	// base plus 16 steps must never reach into the B region
	a_addr_a_in_region: assert property (@(posedge write_clk) disable iff (!rstn)
		fetch_run |-> (addr_a < rom_addr_t'(`VN_ROM_B_OFFSET)));

endmodule
